//--- hw/memory_game_pkg.sv
package memory_game_pkg;

    ////////////////////
    // Board geometry
    ////////////////////

    localparam int MAX_CARDS = 16;

    typedef logic [3:0] card_addr_t;

    // Eight pair colors cover a full board
    typedef logic [2:0] card_color_t;

    typedef enum logic [1:0] {
        EMPTY   = 2'd0,
        HIDDEN  = 2'd1,
        SHOWN   = 2'd2,
        REMOVED = 2'd3
    } card_state_e;

    // One board write, 9 bits
    typedef struct packed {
        card_addr_t  addr;
        card_state_e state;
        card_color_t color;
    } card_write_t;

    ////////////////////
    // Menu side
    ////////////////////

    typedef enum logic [1:0] {
        MENU    = 2'd0,
        OPTIONS = 2'd1,
        PLAY    = 2'd2,
        FINISH  = 2'd3
    } screen_e;

    // Single-cycle strobes plus level select
    typedef struct packed {
        logic       start;
        logic       back;
        logic       level;
        logic [1:0] level_sel;
    } buttons_t;

endpackage

//--- hw/card_dealer.sv
`timescale 1ns/1ns

module card_dealer #(
    parameter logic [15:0] LFSR_SEED = 16'hace1
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       deal_start,
    input  logic [4:0]                 deal_count,
    output memory_game_pkg::card_addr_t  fill_addr,
    output memory_game_pkg::card_color_t fill_color,
    output logic                       fill_valid,
    output logic                       deal_done
);
    import memory_game_pkg::*;

    logic [15:0] lfsr;
    logic        busy;
    card_addr_t  idx;
    logic [4:0]  count;
    card_color_t deck [MAX_CARDS];

    logic [4:0]  span;
    logic [4:0]  offset;
    card_addr_t  pick;

    // Fisher-Yates step: swap place idx with a place in [idx, count-1]
    assign span   = (count > {1'b0, idx}) ? count - {1'b0, idx} : 5'd1;
    assign offset = 5'(lfsr[7:0] % span);
    assign pick   = card_addr_t'({1'b0, idx} + offset);

    // Place idx is final after its swap, so it streams out in the same cycle
    assign fill_valid = busy;
    assign fill_addr  = idx;
    assign fill_color = deck[pick];

    // Free running, so every game gets a different order
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            idx       <= '0;
            count     <= '0;
            deal_done <= 1'b0;
        end else begin
            deal_done <= 1'b0;
            if (deal_start) begin
                busy  <= 1'b1;
                idx   <= '0;
                count <= deal_count;
            end else if (busy) begin
                idx <= idx + 4'd1;
                if ({1'b0, idx} == count - 5'd1) begin
                    busy      <= 1'b0;
                    deal_done <= 1'b1;
                end
            end
        end
    end

    // Deck starts as pairs 0,0,1,1,...
    always_ff @(posedge clk) begin
        if (deal_start) begin
            for (int a = 0; a < MAX_CARDS; a++) begin
                deck[a] <= card_color_t'(a >> 1);
            end
        end else if (busy) begin
            deck[idx]  <= deck[pick];
            deck[pick] <= deck[idx];
        end
    end

endmodule

//--- hw/card_board.sv
`timescale 1ns/1ns

module card_board (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fill_sel,
    input  memory_game_pkg::card_addr_t  fill_addr,
    input  memory_game_pkg::card_color_t fill_color,
    input  logic                         fill_valid,
    input  logic [4:0]                   deal_count,
    input  memory_game_pkg::card_write_t card_write,
    input  logic                         card_write_valid,
    input  memory_game_pkg::card_addr_t  lookup_addr,
    output memory_game_pkg::card_color_t lookup_color,
    output memory_game_pkg::card_state_e lookup_state
);
    import memory_game_pkg::*;

    card_color_t colors [MAX_CARDS];
    card_state_e states [MAX_CARDS];

    logic fill_take;

    // Dealer port only counts while the controller hands it the board
    assign fill_take = fill_sel && fill_valid;

    ////////////////////
    // Card states
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int a = 0; a < MAX_CARDS; a++) begin
                states[a] <= EMPTY;
            end
        end else begin
            if (fill_take) begin
                for (int a = 0; a < MAX_CARDS; a++) begin
                    // Places outside this game are cleared
                    if (5'(a) >= deal_count) begin
                        states[a] <= EMPTY;
                    end else if (card_addr_t'(a) == fill_addr) begin
                        states[a] <= HIDDEN;
                    end
                end
            end
            // Controller writes touch the state only
            if (card_write_valid) begin
                states[card_write.addr] <= card_write.state;
            end
        end
    end

    ////////////////////
    // Card colors
    ////////////////////

    always_ff @(posedge clk) begin
        if (fill_take) begin
            colors[fill_addr] <= fill_color;
        end
    end

    // Lookup is combinational
    assign lookup_color = colors[lookup_addr];
    assign lookup_state = states[lookup_addr];

endmodule

//--- hw/round_timer.sv
`timescale 1ns/1ns

module round_timer #(
    parameter int ROUND_CYCLES = 4000
) (
    input  logic clk,
    input  logic rst,
    input  logic timer_start,
    output logic time_up
);
    localparam int CW = $clog2(ROUND_CYCLES + 1);

    logic [CW-1:0] remaining;
    logic          running;

    always_ff @(posedge clk) begin
        if (rst) begin
            remaining <= '0;
            running   <= 1'b0;
            time_up   <= 1'b0;
        end else if (timer_start) begin
            remaining <= CW'(ROUND_CYCLES);
            running   <= 1'b1;
            time_up   <= 1'b0;
        end else if (running) begin
            if (remaining == '0) begin
                // Stays up until the next start
                time_up <= 1'b1;
                running <= 1'b0;
            end else begin
                remaining <= remaining - 1'b1;
            end
        end
    end

endmodule

//--- hw/game_controller.sv
`timescale 1ns/1ns

module game_controller #(
    parameter int SHOW_CYCLES = 20
) (
    input  logic                         clk,
    input  logic                         rst,
    input  memory_game_pkg::buttons_t    buttons,
    input  logic                         click,
    input  memory_game_pkg::card_addr_t  click_addr,
    input  logic                         deal_done,
    input  logic                         time_up,
    input  memory_game_pkg::card_color_t lookup_color,
    input  memory_game_pkg::card_state_e lookup_state,
    output logic                         deal_start,
    output logic [4:0]                   deal_count,
    output logic                         fill_sel,
    output logic                         timer_start,
    output memory_game_pkg::card_addr_t  lookup_addr,
    output memory_game_pkg::card_write_t card_write,
    output logic                         card_write_valid,
    output logic                         board_update,
    output memory_game_pkg::screen_e     screen,
    output logic [3:0]                   pairs_found
);
    import memory_game_pkg::*;

    localparam int PW = $clog2(SHOW_CYCLES + 1);

    typedef enum logic [3:0] {
        S_MENU, S_OPTIONS, S_DEAL, S_WAIT1, S_REVEAL1, S_WAIT2, S_REVEAL2,
        S_PAUSE, S_RESOLVE1, S_RESOLVE2, S_SWEEP, S_SETTLE, S_FINISH
    } state_e;

    // One turned card
    typedef struct packed {
        card_addr_t  addr;
        card_color_t color;
    } slot_t;

    state_e      state, state_nxt;
    slot_t       slot [2];
    slot_t       slot_nxt [2];
    logic [PW-1:0] pause_ctr, pause_nxt;
    card_addr_t  sweep_ctr, sweep_nxt;
    logic [4:0]  cards_left, cards_left_nxt;
    logic [4:0]  deal_count_nxt;
    logic [3:0]  pairs_nxt;
    card_write_t write_nxt;
    logic        write_valid_nxt;
    logic        write_last, write_last_nxt;
    logic        deal_start_nxt;
    logic        timer_start_nxt;
    logic        click_accept;
    logic        colors_match;
    logic [4:0]  level_count;

    ////////////////////
    // Decode helpers
    ////////////////////

    assign colors_match = (slot[0].color == slot[1].color);
    assign fill_sel     = (state == S_DEAL);
    assign lookup_addr  = (state == S_SWEEP) ? sweep_ctr : click_addr;

    // Second click may not hit the first card, its SHOWN write may still be in flight
    assign click_accept = click && (lookup_state == HIDDEN) &&
                          ((state == S_WAIT1) ||
                           ((state == S_WAIT2) && (click_addr != slot[0].addr)));

    always_comb begin
        case (buttons.level_sel)
            2'd0:    level_count = 5'd8;
            2'd1:    level_count = 5'd12;
            default: level_count = 5'd16;
        endcase
    end

    always_comb begin
        case (state)
            S_MENU:            screen = MENU;
            S_OPTIONS, S_DEAL: screen = OPTIONS;
            S_FINISH:          screen = FINISH;
            default:           screen = PLAY;
        endcase
    end

    ////////////////////
    // Registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= S_MENU;
            deal_start       <= 1'b0;
            timer_start      <= 1'b0;
            deal_count       <= '0;
            card_write_valid <= 1'b0;
            write_last       <= 1'b0;
            board_update     <= 1'b0;
            pairs_found      <= '0;
            pause_ctr        <= '0;
            sweep_ctr        <= '0;
            cards_left       <= '0;
        end else begin
            state            <= state_nxt;
            deal_start       <= deal_start_nxt;
            timer_start      <= timer_start_nxt;
            deal_count       <= deal_count_nxt;
            card_write_valid <= write_valid_nxt;
            write_last       <= write_last_nxt;
            // One pulse after the last write of a group
            board_update     <= card_write_valid && write_last;
            pairs_found      <= pairs_nxt;
            pause_ctr        <= pause_nxt;
            sweep_ctr        <= sweep_nxt;
            cards_left       <= cards_left_nxt;
        end
    end

    always_ff @(posedge clk) begin
        card_write <= write_nxt;
        slot[0]    <= slot_nxt[0];
        slot[1]    <= slot_nxt[1];
    end

    ////////////////////
    // Next state
    ////////////////////

    always_comb begin
        state_nxt       = state;
        deal_start_nxt  = 1'b0;
        timer_start_nxt = 1'b0;
        deal_count_nxt  = deal_count;
        write_nxt       = card_write;
        write_valid_nxt = 1'b0;
        write_last_nxt  = 1'b0;
        pairs_nxt       = pairs_found;
        slot_nxt[0]     = slot[0];
        slot_nxt[1]     = slot[1];
        pause_nxt       = '0;
        sweep_nxt       = '0;
        cards_left_nxt  = cards_left;

        case (state)
            S_MENU: begin
                if (buttons.start) state_nxt = S_OPTIONS;
            end
            S_OPTIONS: begin
                if (buttons.level) begin
                    // Timer restarts here so time_up is low before play
                    deal_start_nxt  = 1'b1;
                    timer_start_nxt = 1'b1;
                    deal_count_nxt  = level_count;
                    cards_left_nxt  = level_count;
                    pairs_nxt       = '0;
                    state_nxt       = S_DEAL;
                end else if (buttons.back) begin
                    state_nxt = S_MENU;
                end
            end
            S_DEAL: begin
                if (deal_done) state_nxt = S_WAIT1;
            end
            S_WAIT1: begin
                if (time_up) begin
                    state_nxt = S_SWEEP;
                end else if (click_accept) begin
                    slot_nxt[0] = '{addr: click_addr, color: lookup_color};
                    state_nxt   = S_REVEAL1;
                end
            end
            S_REVEAL1: begin
                write_nxt       = '{addr: slot[0].addr, state: SHOWN, color: slot[0].color};
                write_valid_nxt = 1'b1;
                write_last_nxt  = 1'b1;
                state_nxt       = S_WAIT2;
            end
            S_WAIT2: begin
                if (time_up) begin
                    state_nxt = S_SWEEP;
                end else if (click_accept) begin
                    slot_nxt[1] = '{addr: click_addr, color: lookup_color};
                    state_nxt   = S_REVEAL2;
                end
            end
            S_REVEAL2: begin
                write_nxt       = '{addr: slot[1].addr, state: SHOWN, color: slot[1].color};
                write_valid_nxt = 1'b1;
                write_last_nxt  = 1'b1;
                state_nxt       = S_PAUSE;
            end
            S_PAUSE: begin
                if (time_up) begin
                    state_nxt = S_SWEEP;
                end else if (pause_ctr == PW'(SHOW_CYCLES - 1)) begin
                    state_nxt = S_RESOLVE1;
                end else begin
                    pause_nxt = pause_ctr + 1'b1;
                end
            end
            S_RESOLVE1: begin
                write_nxt.addr  = slot[0].addr;
                write_nxt.state = colors_match ? REMOVED : HIDDEN;
                write_nxt.color = slot[0].color;
                write_valid_nxt = 1'b1;
                if (colors_match) begin
                    cards_left_nxt = cards_left - 5'd2;
                    pairs_nxt      = (pairs_found == 4'd15) ? 4'd15 : pairs_found + 4'd1;
                end
                state_nxt = S_RESOLVE2;
            end
            S_RESOLVE2: begin
                write_nxt.addr  = slot[1].addr;
                write_nxt.state = colors_match ? REMOVED : HIDDEN;
                write_nxt.color = slot[1].color;
                write_valid_nxt = 1'b1;
                write_last_nxt  = 1'b1;
                state_nxt       = S_SETTLE;
            end
            S_SWEEP: begin
                write_nxt       = '{addr: sweep_ctr, state: REMOVED, color: lookup_color};
                write_valid_nxt = 1'b1;
                if ({1'b0, sweep_ctr} == deal_count - 5'd1) begin
                    write_last_nxt = 1'b1;
                    cards_left_nxt = '0;
                    state_nxt      = S_SETTLE;
                end else begin
                    sweep_nxt = sweep_ctr + 4'd1;
                end
            end
            S_SETTLE: begin
                // Last write of the group is on the bus in this cycle
                if (cards_left == '0) begin
                    state_nxt = S_FINISH;
                end else if (time_up) begin
                    state_nxt = S_SWEEP;
                end else begin
                    state_nxt = S_WAIT1;
                end
            end
            S_FINISH: begin
                if (buttons.back) state_nxt = S_MENU;
            end
            default: begin
                state_nxt = S_MENU;
            end
        endcase
    end

endmodule

//--- hw/memory_game_top.sv
`timescale 1ns/1ns

module memory_game_top #(
    parameter int          SHOW_CYCLES  = 20,
    parameter int          ROUND_CYCLES = 4000,
    parameter logic [15:0] LFSR_SEED    = 16'hace1
) (
    input  logic                         clk,
    input  logic                         rst,
    input  memory_game_pkg::buttons_t    buttons,
    input  logic                         click,
    input  memory_game_pkg::card_addr_t  click_addr,
    output memory_game_pkg::screen_e     screen,
    output memory_game_pkg::card_write_t card_write,
    output logic                         card_write_valid,
    output logic                         board_update,
    output logic [3:0]                   pairs_found
);
    import memory_game_pkg::*;

    logic        deal_start;
    logic        deal_done;
    logic [4:0]  deal_count;
    logic        fill_sel;
    logic        fill_valid;
    card_addr_t  fill_addr;
    card_color_t fill_color;
    logic        timer_start;
    logic        time_up;
    card_addr_t  lookup_addr;
    card_color_t lookup_color;
    card_state_e lookup_state;

    game_controller #(
        .SHOW_CYCLES(SHOW_CYCLES)
    ) u_controller (
        .clk, .rst, .buttons, .click, .click_addr, .deal_done, .time_up,
        .lookup_color, .lookup_state, .deal_start, .deal_count, .fill_sel,
        .timer_start, .lookup_addr, .card_write, .card_write_valid,
        .board_update, .screen, .pairs_found
    );

    card_dealer #(
        .LFSR_SEED(LFSR_SEED)
    ) u_dealer (
        .clk, .rst, .deal_start, .deal_count, .fill_addr, .fill_color,
        .fill_valid, .deal_done
    );

    card_board u_board (
        .clk, .rst, .fill_sel, .fill_addr, .fill_color, .fill_valid, .deal_count,
        .card_write, .card_write_valid, .lookup_addr, .lookup_color, .lookup_state
    );

    round_timer #(
        .ROUND_CYCLES(ROUND_CYCLES)
    ) u_timer (
        .clk, .rst, .timer_start, .time_up
    );

endmodule

//--- sim/game_monitor.sv
`timescale 1ns/1ns

module game_monitor (
    input  logic                         clk,
    input  logic                         rst,
    input  memory_game_pkg::screen_e     screen,
    input  memory_game_pkg::card_write_t card_write,
    input  logic                         card_write_valid,
    input  logic                         board_update,
    input  logic [3:0]                   pairs_found
);
    import memory_game_pkg::*;

    // Expected write plus the pair count seen with it
    typedef struct packed {
        card_addr_t  addr;
        card_state_e state;
        logic [3:0]  pairs;
    } expect_t;

    expect_t exp_q [$];
    string   name_q [$];
    logic    last_q [$];
    int      errors = 0;
    int      writes_checked = 0;
    logic    update_due = 1'b0;

    // Last marks the final write of a group, board_update follows it
    function void expect_write(string name, card_addr_t a, card_state_e s, logic [3:0] p,
                               logic last);
        exp_q.push_back('{addr: a, state: s, pairs: p});
        name_q.push_back(name);
        last_q.push_back(last);
    endfunction

    function void fail_value(string name, int exp, int act);
        $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
        errors++;
    endfunction

    function void fail_note(string text);
        $display("Error: %s", text);
        errors++;
    endfunction

    function void check_screen(string name, screen_e exp);
        if (screen != exp) fail_value(name, exp, screen);
    endfunction

    function int pending();
        return exp_q.size();
    endfunction

    // Outputs are sampled mid-cycle
    always @(negedge clk) begin
        expect_t act;
        if (!rst) begin
            if (board_update != update_due) begin
                fail_value("board_update", update_due, board_update);
            end
            update_due = 1'b0;
            if (card_write_valid) begin
                act = '{addr: card_write.addr, state: card_write.state, pairs: pairs_found};
                if (exp_q.size() == 0) begin
                    fail_note($sformatf("unexpected write to card %0d", card_write.addr));
                end else begin
                    if (act != exp_q[0]) fail_value(name_q[0], exp_q[0], act);
                    update_due = last_q[0];
                    void'(exp_q.pop_front());
                    void'(name_q.pop_front());
                    void'(last_q.pop_front());
                    writes_checked++;
                end
            end
        end
    end

endmodule

//--- sim/game_checker.sv
`timescale 1ns/1ns

module game_checker (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         click_accept,
    input  memory_game_pkg::card_addr_t  click_addr,
    input  memory_game_pkg::card_write_t card_write,
    input  logic                         card_write_valid,
    input  memory_game_pkg::screen_e     screen,
    input  logic [3:0]                   pairs_found
);
    import memory_game_pkg::*;

    a_write_in_play: assert property (@(posedge clk) disable iff (rst)
        card_write_valid |-> screen == PLAY)
        else $error("board write outside the PLAY screen");

    // Reveal lands two cycles after the accepting edge
    a_reveal_delay: assert property (@(posedge clk) disable iff (rst)
        click_accept |-> ##2 (card_write_valid && card_write.state == SHOWN &&
                              card_write.addr == $past(click_addr, 2)))
        else $error("reveal write missing two cycles after an accepted click");

    // Count is only cleared on the options screen
    a_pairs_rise: assert property (@(posedge clk) disable iff (rst)
        (screen != OPTIONS && $past(screen) != OPTIONS) |-> pairs_found >= $past(pairs_found))
        else $error("pairs_found went down during a game");

endmodule

bind game_controller game_checker u_checker (
    .clk(clk), .rst(rst), .click_accept(click_accept), .click_addr(click_addr),
    .card_write(card_write), .card_write_valid(card_write_valid),
    .screen(screen), .pairs_found(pairs_found)
);

//--- sim/memory_game_tb.sv
`timescale 1ns/1ns

module memory_game_tb;
    import memory_game_pkg::*;

    localparam int SHOW_CYCLES  = 20;
    localparam int ROUND_CYCLES = 4000;
    // Six tests, the time-out one dominated by the round length
    localparam int TIMEOUT_CYCLES = 20000;

    typedef struct packed {
        card_state_e state;
        logic [3:0]  pairs;
    } pair_result_t;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    buttons_t    buttons = '0;
    logic        click = 1'b0;
    card_addr_t  click_addr = '0;
    screen_e     screen;
    card_write_t card_write;
    logic        card_write_valid;
    logic        board_update;
    logic [3:0]  pairs_found;

    int          seed = 67323;
    int          cycles = 0;
    card_color_t seen_color [MAX_CARDS];
    logic        gone [MAX_CARDS];
    logic [3:0]  exp_pairs;

    memory_game_top #(
        .SHOW_CYCLES(SHOW_CYCLES), .ROUND_CYCLES(ROUND_CYCLES)
    ) u_dut (
        .clk, .rst, .buttons, .click, .click_addr, .screen, .card_write,
        .card_write_valid, .board_update, .pairs_found
    );

    game_monitor u_mon (
        .clk, .rst, .screen, .card_write, .card_write_valid, .board_update, .pairs_found
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Run stopped at the cycle limit of %0d", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Equal colors remove both cards and count a pair
    function automatic pair_result_t expected_pair(card_color_t a, card_color_t b,
                                                   logic [3:0] pairs);
        pair_result_t r;
        if (a == b) begin
            r.state = REMOVED;
            r.pairs = (pairs == 4'd15) ? pairs : pairs + 4'd1;
        end else begin
            r.state = HIDDEN;
            r.pairs = pairs;
        end
        return r;
    endfunction

    function automatic int first_hidden();
        for (int i = 0; i < MAX_CARDS; i++) begin
            if (!gone[i]) return i;
        end
        return -1;
    endfunction

    // Card of the same recorded color further up the board
    function automatic int partner_of(int i);
        for (int j = i + 1; j < MAX_CARDS; j++) begin
            if (!gone[j] && seen_color[j] == seen_color[i]) return j;
        end
        return -1;
    endfunction

    task automatic press(input buttons_t b);
        @(posedge clk);
        #1 buttons = b;
        @(posedge clk);
        #1 buttons = '0;
    endtask

    task automatic click_card(input card_addr_t a);
        @(posedge clk);
        #1 click = 1'b1;
        click_addr = a;
        @(posedge clk);
        #1 click = 1'b0;
    endtask

    task automatic wait_screen(input string name, input screen_e exp, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (screen != exp && n < limit) begin
            @(negedge clk);
            n++;
        end
        u_mon.check_screen(name, exp);
    endtask

    task automatic take_write(output card_write_t w);
        int n;
        n = 0;
        @(negedge clk);
        while (!card_write_valid && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!card_write_valid) u_mon.fail_note("expected board write never came");
        w = card_write;
    endtask

    task automatic play_pair(input string name, input card_addr_t a, input card_addr_t b,
                             input bit probe);
        card_write_t  w;
        card_color_t  ca;
        card_color_t  cb;
        pair_result_t r;
        card_addr_t   dead [$];
        card_addr_t   live [$];
        u_mon.expect_write(name, a, SHOWN, exp_pairs, 1'b1);
        click_card(a);
        take_write(w);
        ca = w.color;
        if (probe) begin
            // Shown card, then a removed one, must both be ignored
            click_card(a);
            for (int i = 0; i < MAX_CARDS; i++) begin
                if (gone[i]) dead.push_back(card_addr_t'(i));
            end
            if (dead.size() > 0) click_card(dead[$unsigned($random(seed)) % dead.size()]);
            repeat (3) @(posedge clk);
        end
        u_mon.expect_write(name, b, SHOWN, exp_pairs, 1'b1);
        click_card(b);
        take_write(w);
        cb = w.color;
        if (probe) begin
            // A hidden card clicked inside the pause
            for (int i = 0; i < MAX_CARDS; i++) begin
                if (!gone[i] && i != a && i != b) live.push_back(card_addr_t'(i));
            end
            repeat (2 + ($unsigned($random(seed)) % 8)) @(posedge clk);
            if (live.size() > 0) click_card(live[$unsigned($random(seed)) % live.size()]);
        end
        r = expected_pair(ca, cb, exp_pairs);
        u_mon.expect_write(name, a, r.state, r.pairs, 1'b0);
        u_mon.expect_write(name, b, r.state, r.pairs, 1'b1);
        exp_pairs = r.pairs;
        take_write(w);
        take_write(w);
        seen_color[a] = ca;
        seen_color[b] = cb;
        gone[a] = (r.state == REMOVED);
        gone[b] = (r.state == REMOVED);
    endtask

    initial begin
        int cnt;
        int h;
        int removed;
        for (int i = 0; i < MAX_CARDS; i++) gone[i] = 1'b0;
        exp_pairs = '0;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;

        ////////////////////
        // Menu flow, buttons act on the next edge
        wait_screen("reset_screen", MENU, 0);
        press('{start: 1'b1, back: 1'b0, level: 1'b0, level_sel: 2'd0});
        wait_screen("start_to_options", OPTIONS, 0);
        press('{start: 1'b0, back: 1'b1, level: 1'b0, level_sel: 2'd0});
        wait_screen("back_to_menu", MENU, 0);
        press('{start: 1'b1, back: 1'b0, level: 1'b0, level_sel: 2'd0});
        wait_screen("start_again", OPTIONS, 0);
        press('{start: 1'b0, back: 1'b0, level: 1'b1, level_sel: 2'd2});
        wait_screen("level_to_play", PLAY, 40);

        ////////////////////
        // Deal and pair rule, neighbours paired in address order
        for (int a = 0; a < MAX_CARDS; a += 2) begin
            play_pair("pair_rule", card_addr_t'(a), card_addr_t'(a + 1), 1'b0);
        end
        for (int c = 0; c < 8; c++) begin
            cnt = 0;
            for (int i = 0; i < MAX_CARDS; i++) if (seen_color[i] == card_color_t'(c)) cnt++;
            if (cnt != 2) u_mon.fail_value($sformatf("deal_color_%0d", c), 2, cnt);
        end

        ////////////////////
        // Ignored clicks, then clear the board
        h = first_hidden();
        removed = 0;
        for (int i = 0; i < MAX_CARDS; i++) begin
            if (gone[i]) removed++;
        end
        if (h >= 0 && removed == 0) begin
            // One pair off first so a removed card is there to click
            play_pair("clear_board", card_addr_t'(h), card_addr_t'(partner_of(h)), 1'b0);
            h = first_hidden();
        end
        if (h >= 0) begin
            play_pair("ignored_click", card_addr_t'(h), card_addr_t'(partner_of(h)), 1'b1);
        end
        for (int i = 0; i < MAX_CARDS; i++) begin
            if (!gone[i]) begin
                play_pair("clear_board", card_addr_t'(i), card_addr_t'(partner_of(i)), 1'b0);
            end
        end
        wait_screen("all_removed", FINISH, 10);
        press('{start: 1'b0, back: 1'b1, level: 1'b0, level_sel: 2'd0});
        wait_screen("finish_to_menu", MENU, 0);

        ////////////////////
        // Time-out sweep on an 8-card game
        press('{start: 1'b1, back: 1'b0, level: 1'b0, level_sel: 2'd0});
        wait_screen("timeout_options", OPTIONS, 0);
        press('{start: 1'b0, back: 1'b0, level: 1'b1, level_sel: 2'd0});
        exp_pairs = '0;
        for (int a = 0; a < 8; a++) begin
            u_mon.expect_write("sweep", card_addr_t'(a), REMOVED, 4'd0, a == 7);
        end
        wait_screen("timeout_play", PLAY, 40);
        wait_screen("timeout_finish", FINISH, ROUND_CYCLES + 100);
        // Monitor still has to see the update strobe of the sweep
        @(posedge clk);
        if (u_mon.pending() != 0) u_mon.fail_value("writes_left_over", 0, u_mon.pending());

        $display("Errors: %0d, writes checked: %0d", u_mon.errors, u_mon.writes_checked);
        if (u_mon.errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
hw/memory_game_pkg.sv
hw/card_dealer.sv
hw/card_board.sv
hw/round_timer.sv
hw/game_controller.sv
hw/memory_game_top.sv
sim/game_monitor.sv
sim/game_checker.sv
sim/memory_game_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= memory_game_tb
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell cat verilog.f)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) verilog.f
	$(VERILATOR) $(VFLAGS) -f verilog.f --top-module $(TOP) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
